// File: design/circular_buffer.sv
`timescale 1ns/1ns

module circular_buffer #(
    parameter int BUFFER_SIZE    = noc_params::BUFFER_SIZE,
    parameter int PIPELINE_DEPTH = noc_params::PIPELINE_DEPTH
)(
    input  logic              clk,
    input  logic              rst,
    input  noc_params::flit_t data_i,
    input  logic              read_i,
    input  logic              write_i,
    output noc_params::flit_t data_o,
    output logic              is_full_o,
    output logic              is_empty_o,
    output logic              on_off_o
);

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    localparam int CNT_W = $clog2(BUFFER_SIZE + 1);

    noc_params::flit_t mem [BUFFER_SIZE];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_read;
    logic              do_write;

    assign do_read  = read_i & ~is_empty_o;   // Empty reads ignored
    assign do_write = write_i & ~is_full_o;   // Full writes ignored

    assign data_o     = mem[rd_ptr];          // Head flit always visible
    assign is_empty_o = (count == '0);
    assign is_full_o  = (count == CNT_W'(BUFFER_SIZE));
    assign on_off_o   = (count <= CNT_W'(BUFFER_SIZE - PIPELINE_DEPTH));

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(BUFFER_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
        end
    end

endmodule

// File: design/input_buffer.sv
`timescale 1ns/1ns

module input_buffer #(
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
)(
    input  logic                           clk,
    input  logic                           rst,
    input  noc_params::flit_t              data_i,
    input  logic                           read_i,
    input  logic                           write_i,
    input  logic [noc_params::VC_SIZE-1:0] vc_new_i,
    input  logic                           vc_valid_i,
    output noc_params::flit_t              data_o,
    output logic                           is_empty_o,
    output logic                           on_off_o,
    output noc_params::port_t              out_port_o,
    output logic                           vc_request_o,
    output logic                           switch_request_o,
    output logic                           vc_allocatable_o,
    output logic                           error_o
);

    noc_params::buf_state_t         ss;
    noc_params::buf_state_t         ss_next;
    noc_params::port_t              route_port;
    noc_params::port_t              out_port_next;
    noc_params::flit_t              read_flit;
    logic [noc_params::VC_SIZE-1:0] downstream_vc;
    logic [noc_params::VC_SIZE-1:0] downstream_vc_next;
    logic read_cmd;
    logic write_cmd;
    logic is_full;
    logic end_packet;                 // Tail of current packet already buffered
    logic end_packet_next;
    logic vc_allocatable_next;
    logic error_next;
    logic in_head;
    logic in_tail;
    logic out_tail;
    logic body_ok;

    assign in_head  = (data_i.flit_label == noc_params::HEAD)
                    | (data_i.flit_label == noc_params::HEADTAIL);
    assign in_tail  = (data_i.flit_label == noc_params::TAIL)
                    | (data_i.flit_label == noc_params::HEADTAIL);
    assign out_tail = (read_flit.flit_label == noc_params::TAIL)
                    | (read_flit.flit_label == noc_params::HEADTAIL);
    assign body_ok  = write_i & ~in_head & ~end_packet;   // Continues open packet

    circular_buffer circular_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .data_i     (data_i),
        .read_i     (read_cmd),
        .write_i    (write_cmd),
        .data_o     (read_flit),
        .is_full_o  (is_full),
        .is_empty_o (is_empty_o),
        .on_off_o   (on_off_o)
    );

    route_compute #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) route_compute_inst (
        .dest_i     (data_i.data[2*noc_params::COORD_SIZE-1:0]),
        .out_port_o (route_port)
    );

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            ss               <= noc_params::IDLE;
            out_port_o       <= noc_params::LOCAL;
            downstream_vc    <= '0;
            end_packet       <= 1'b0;
            vc_allocatable_o <= 1'b0;
            error_o          <= 1'b0;
        end
        else
        begin
            ss               <= ss_next;
            out_port_o       <= out_port_next;
            downstream_vc    <= downstream_vc_next;
            end_packet       <= end_packet_next;
            vc_allocatable_o <= vc_allocatable_next;
            error_o          <= error_next;
        end
    end

    always_comb
    begin
        data_o              = read_flit;
        data_o.vc_id        = downstream_vc;   // Relabel for next router
        ss_next             = ss;
        out_port_next       = out_port_o;
        downstream_vc_next  = downstream_vc;
        end_packet_next     = end_packet;
        vc_allocatable_next = 1'b0;
        read_cmd            = 1'b0;
        write_cmd           = 1'b0;
        vc_request_o        = 1'b0;
        switch_request_o    = 1'b0;
        error_next          = write_i & is_full;   // Overflowing flit is lost

        unique case (ss)
            noc_params::IDLE:
            begin
                if (write_i & in_head & is_empty_o)
                begin
                    ss_next         = noc_params::VA;
                    out_port_next   = route_port;
                    write_cmd       = 1'b1;
                    end_packet_next = in_tail;   // Single-flit packet
                end
                if ((write_i & ~in_head) | read_i | vc_valid_i)
                begin
                    error_next = 1'b1;
                end
            end

            noc_params::VA:
            begin
                vc_request_o = 1'b1;
                if (vc_valid_i)
                begin
                    ss_next            = noc_params::SA;
                    downstream_vc_next = vc_new_i;
                end
                write_cmd = body_ok;
                if (body_ok & ~is_full)
                begin
                    end_packet_next = in_tail;
                end
                if ((write_i & (in_head | end_packet)) | read_i)
                begin
                    error_next = 1'b1;
                end
            end

            noc_params::SA:
            begin
                switch_request_o = 1'b1;
                read_cmd         = read_i;
                write_cmd        = body_ok;
                if (body_ok & ~is_full)
                begin
                    end_packet_next = in_tail;
                end
                if (read_i & out_tail)
                begin
                    ss_next             = noc_params::IDLE;
                    vc_allocatable_next = 1'b1;   // Hand downstream VC back
                    end_packet_next     = 1'b0;
                end
                if ((write_i & (in_head | end_packet)) | vc_valid_i)
                begin
                    error_next = 1'b1;
                end
            end

            default:
            begin
                ss_next         = noc_params::IDLE;
                end_packet_next = 1'b0;
                error_next      = 1'b1;
            end
        endcase
    end

endmodule

// File: design/input_unit.sv
`timescale 1ns/1ns

module input_unit #(
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
)(
    input  logic                          clk,
    input  logic                          rst,
    input  noc_params::flit_t             data_i,
    input  logic                          valid_i,
    output logic [noc_params::VC_NUM-1:0] on_off_o,
    output noc_params::flit_t             data_o,
    output noc_params::port_t             out_port_o,
    output logic                          valid_o,
    output logic                          error_o
);

    noc_params::flit_t              buf_data [noc_params::VC_NUM];
    noc_params::port_t              buf_port [noc_params::VC_NUM];
    logic [noc_params::VC_SIZE-1:0] vc_new   [noc_params::VC_NUM];
    logic [noc_params::VC_NUM-1:0]  wr_en;
    logic [noc_params::VC_NUM-1:0]  rd_en;
    logic [noc_params::VC_NUM-1:0]  is_empty;
    logic [noc_params::VC_NUM-1:0]  vc_request;
    logic [noc_params::VC_NUM-1:0]  vc_valid;
    logic [noc_params::VC_NUM-1:0]  switch_request;
    logic [noc_params::VC_NUM-1:0]  vc_allocatable;
    logic [noc_params::VC_NUM-1:0]  buf_error;

    for (genvar v = 0; v < noc_params::VC_NUM; v++)
    begin : g_vc
        assign wr_en[v] = valid_i & (int'(data_i.vc_id) == v);   // Demux on input VC

        input_buffer #(
            .ROUTER_X (ROUTER_X),
            .ROUTER_Y (ROUTER_Y)
        ) input_buffer_inst (
            .clk              (clk),
            .rst              (rst),
            .data_i           (data_i),
            .read_i           (rd_en[v]),
            .write_i          (wr_en[v]),
            .vc_new_i         (vc_new[v]),
            .vc_valid_i       (vc_valid[v]),
            .data_o           (buf_data[v]),
            .is_empty_o       (is_empty[v]),
            .on_off_o         (on_off_o[v]),
            .out_port_o       (buf_port[v]),
            .vc_request_o     (vc_request[v]),
            .switch_request_o (switch_request[v]),
            .vc_allocatable_o (vc_allocatable[v]),
            .error_o          (buf_error[v])
        );
    end

    vc_allocator vc_allocator_inst (
        .clk              (clk),
        .rst              (rst),
        .vc_request_i     (vc_request),
        .out_port_i       (buf_port),
        .vc_allocatable_i (vc_allocatable),
        .vc_valid_o       (vc_valid),
        .vc_new_o         (vc_new)
    );

    switch_allocator switch_allocator_inst (
        .clk              (clk),
        .rst              (rst),
        .switch_request_i (switch_request),
        .is_empty_i       (is_empty),
        .flit_i           (buf_data),
        .port_i           (buf_port),
        .read_o           (rd_en),
        .data_o           (data_o),
        .out_port_o       (out_port_o),
        .valid_o          (valid_o)
    );

    assign error_o = |buf_error;   // Any VC's protocol error

endmodule

// File: design/noc_params.sv
package noc_params;

    localparam int VC_NUM         = 2;   // Virtual channels per port
    localparam int VC_SIZE        = 1;   // Bits of a VC identifier
    localparam int FLIT_DATA_SIZE = 16;  // Payload width
    localparam int COORD_SIZE     = 2;   // Bits per mesh coordinate
    localparam int BUFFER_SIZE    = 8;   // Flits per VC buffer
    localparam int PIPELINE_DEPTH = 2;   // Free slots needed to keep on/off high
    localparam int PORT_NUM       = 5;   // Router ports

    typedef enum logic [1:0]
    {
        HEAD,
        BODY,
        TAIL,
        HEADTAIL                         // Single-flit packet
    } flit_label_t;

    typedef enum logic [2:0]
    {
        LOCAL,
        NORTH,
        SOUTH,
        WEST,
        EAST
    } port_t;

    typedef enum logic [1:0]
    {
        IDLE,
        VA,                              // Waiting for a downstream VC
        SA                               // Competing for the switch
    } buf_state_t;

    // Head flits carry the destination in the low payload bits,
    // x in data[3:2] and y in data[1:0]
    typedef struct packed
    {
        flit_label_t                flit_label;
        logic [VC_SIZE-1:0]         vc_id;
        logic [FLIT_DATA_SIZE-1:0]  data;
    } flit_t;

endpackage

// File: design/route_compute.sv
`timescale 1ns/1ns

module route_compute #(
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
)(
    input  logic [2*noc_params::COORD_SIZE-1:0] dest_i,
    output noc_params::port_t                   out_port_o
);

    localparam logic [noc_params::COORD_SIZE-1:0] HERE_X = ROUTER_X[noc_params::COORD_SIZE-1:0];
    localparam logic [noc_params::COORD_SIZE-1:0] HERE_Y = ROUTER_Y[noc_params::COORD_SIZE-1:0];

    logic [noc_params::COORD_SIZE-1:0] dest_x;
    logic [noc_params::COORD_SIZE-1:0] dest_y;

    assign dest_x = dest_i[2*noc_params::COORD_SIZE-1:noc_params::COORD_SIZE];
    assign dest_y = dest_i[noc_params::COORD_SIZE-1:0];

    // X is resolved fully before any Y hop
    always_comb
    begin
        if (dest_x > HERE_X)
        begin
            out_port_o = noc_params::EAST;
        end
        else if (dest_x < HERE_X)
        begin
            out_port_o = noc_params::WEST;
        end
        else if (dest_y > HERE_Y)
        begin
            out_port_o = noc_params::NORTH;
        end
        else if (dest_y < HERE_Y)
        begin
            out_port_o = noc_params::SOUTH;
        end
        else
        begin
            out_port_o = noc_params::LOCAL;   // Arrived
        end
    end

endmodule

// File: design/switch_allocator.sv
`timescale 1ns/1ns

module switch_allocator (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [noc_params::VC_NUM-1:0] switch_request_i,
    input  logic [noc_params::VC_NUM-1:0] is_empty_i,
    input  noc_params::flit_t             flit_i [noc_params::VC_NUM],
    input  noc_params::port_t             port_i [noc_params::VC_NUM],
    output logic [noc_params::VC_NUM-1:0] read_o,
    output noc_params::flit_t             data_o,
    output noc_params::port_t             out_port_o,
    output logic                          valid_o
);

    logic [noc_params::VC_SIZE-1:0] last_grant;
    logic [noc_params::VC_SIZE-1:0] grant_idx;
    logic                           grant_valid;
    logic [noc_params::VC_NUM-1:0]  eligible;

    assign eligible = switch_request_i & ~is_empty_i;   // Only buffers with a flit

    always_comb
    begin
        int idx;
        grant_idx   = last_grant;
        grant_valid = 1'b0;
        read_o      = '0;
        // Farthest offset first so the nearest one after the last grant wins
        for (int off = noc_params::VC_NUM; off >= 1; off--)
        begin
            idx = (int'(last_grant) + off) % noc_params::VC_NUM;
            if (eligible[idx])
            begin
                grant_idx   = idx[noc_params::VC_SIZE-1:0];
                grant_valid = 1'b1;
            end
        end
        read_o[grant_idx] = grant_valid;
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            valid_o    <= 1'b0;
            last_grant <= '1;               // VC 0 is first in line
        end
        else
        begin
            valid_o <= grant_valid;
            if (grant_valid)
            begin
                last_grant <= grant_idx;
            end
        end
    end

    // Switch traversal register
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            data_o     <= flit_i[grant_idx];
            out_port_o <= port_i[grant_idx];
        end
    end

endmodule

// File: design/vc_allocator.sv
`timescale 1ns/1ns

module vc_allocator (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [noc_params::VC_NUM-1:0]  vc_request_i,
    input  noc_params::port_t              out_port_i [noc_params::VC_NUM],
    input  logic [noc_params::VC_NUM-1:0]  vc_allocatable_i,
    output logic [noc_params::VC_NUM-1:0]  vc_valid_o,
    output logic [noc_params::VC_SIZE-1:0] vc_new_o [noc_params::VC_NUM]
);

    logic [noc_params::VC_NUM-1:0]  busy  [noc_params::PORT_NUM];   // Per port, per downstream VC
    logic [noc_params::VC_NUM-1:0]  taken [noc_params::PORT_NUM];
    noc_params::port_t              owner_port [noc_params::VC_NUM];
    logic [noc_params::VC_SIZE-1:0] owner_vc   [noc_params::VC_NUM];

    // Lower input VCs pick first and claim their VC in the scratch table
    always_comb
    begin
        taken = busy;
        for (int i = 0; i < noc_params::VC_NUM; i++)
        begin
            vc_valid_o[i] = 1'b0;
            vc_new_o[i]   = '0;
            if (vc_request_i[i])
            begin
                for (int v = noc_params::VC_NUM - 1; v >= 0; v--)   // Lowest free wins
                begin
                    if (!taken[out_port_i[i]][v])
                    begin
                        vc_valid_o[i] = 1'b1;
                        vc_new_o[i]   = v[noc_params::VC_SIZE-1:0];
                    end
                end
                if (vc_valid_o[i])
                begin
                    taken[out_port_i[i]][vc_new_o[i]] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            for (int p = 0; p < noc_params::PORT_NUM; p++)
            begin
                busy[p] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < noc_params::VC_NUM; i++)
            begin
                if (vc_allocatable_i[i])
                begin
                    busy[owner_port[i]][owner_vc[i]] <= 1'b0;
                end
            end
            for (int i = 0; i < noc_params::VC_NUM; i++)
            begin
                if (vc_valid_o[i])
                begin
                    busy[out_port_i[i]][vc_new_o[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < noc_params::VC_NUM; i++)
        begin
            if (vc_valid_o[i])
            begin
                owner_port[i] <= out_port_i[i];
                owner_vc[i]   <= vc_new_o[i];
            end
        end
    end

endmodule

// File: dv/input_unit_trace.txt
# S vc label data | E port vc label data | X error strobe expected, data in hex
# label 0 HEAD 1 BODY 2 TAIL 3 HEADTAIL, port 0 LOCAL 1 NORTH 2 SOUTH 3 WEST 4 EAST
# Single-flit packets from router (1,1) to each direction
E 0 0 3 1005
S 0 3 1005
E 1 0 3 1106
S 0 3 1106
E 2 0 3 1204
S 0 3 1204
E 3 0 3 1301
S 0 3 1301
E 4 0 3 1409
S 0 3 1409
# Four-flit packet to north
E 1 0 0 2006
E 1 0 1 2a01
E 1 0 1 2b02
E 1 0 2 2c03
S 0 0 2006
S 0 1 2a01
S 0 1 2b02
S 0 2 2c03
# Two packets to east on both input VCs, flits interleave round-robin
E 4 0 0 3009
E 4 1 0 3109
E 4 0 1 3a00
E 4 1 1 3b00
E 4 0 2 3c00
E 4 1 2 3d00
S 0 0 3009
S 1 0 3109
S 0 1 3a00
S 1 1 3b00
S 0 2 3c00
S 1 2 3d00
# Downstream VC 0 of east is free again
E 4 0 3 4009
S 1 3 4009
# Body flit into an idle VC
S 0 1 5555
X
# Long packet to west while on/off is watched
E 3 0 0 6001
E 3 0 1 6a01
E 3 0 1 6b01
E 3 0 1 6c01
E 3 0 1 6d01
E 3 0 2 6e01
S 0 0 6001
S 0 1 6a01
S 0 1 6b01
S 0 1 6c01
S 0 1 6d01
S 0 2 6e01

// File: dv/tb_input_unit.sv
`timescale 1ns/1ns

module tb_input_unit;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                          clk = 1'b0;
    logic                          rst;
    noc_params::flit_t             data_i;
    logic                          valid_i;
    logic [noc_params::VC_NUM-1:0] on_off_o;
    noc_params::flit_t             data_o;
    noc_params::port_t             out_port_o;
    logic                          valid_o;
    logic                          error_o;

    noc_params::flit_t                     exp_q  [noc_params::PORT_NUM][$];  // Per output port
    logic [noc_params::FLIT_DATA_SIZE-1:0] held_q [noc_params::VC_NUM][$];    // Flits inside each VC
    logic [noc_params::VC_NUM-1:0]         pkt_open;                          // Packet started, no tail yet
    int                                    err_pending;

    input_unit input_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .data_i     (data_i),
        .valid_i    (valid_i),
        .on_off_o   (on_off_o),
        .data_o     (data_o),
        .out_port_o (out_port_o),
        .valid_o    (valid_o),
        .error_o    (error_o)
    );

    always #20 clk = ~clk;   // 40 ns period

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_flit(input string name, input noc_params::flit_t exp,
                              input noc_params::flit_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("Fail at %0t ns: %s expected %s/%0d/%h got %s/%0d/%h", $time,
                     name, exp.flit_label.name(), exp.vc_id, exp.data,
                     act.flit_label.name(), act.vc_id, act.data));
        end
    endtask

    task automatic check_port(input string name, input noc_params::port_t exp,
                              input noc_params::port_t act);
        if (act !== exp)
        begin
            stop_run($sformatf("Fail at %0t ns: %s expected %s got %s", $time, name,
                     exp.name(), act.name()));
        end
    endtask

    task automatic check_on_off(input int vc, input logic exp, input logic act);
        if (act !== exp)
        begin
            stop_run($sformatf("Fail at %0t ns: on_off_o[%0d] expected %b got %b", $time, vc,
                     exp, act));
        end
    endtask

    // Payloads are unique, so the data picks the port queue and the source VC
    task automatic match_output();
        int port;
        int src;
        port = -1;
        src  = -1;
        for (int p = 0; p < noc_params::PORT_NUM; p++)
        begin
            if (port < 0 && exp_q[p].size() != 0 && exp_q[p][0].data == data_o.data)
                port = p;
        end
        for (int v = 0; v < noc_params::VC_NUM; v++)
        begin
            if (src < 0 && held_q[v].size() != 0 && held_q[v][0] == data_o.data)
                src = v;
        end
        if (port < 0 || src < 0)
        begin
            stop_run($sformatf("Unexpected flit with data %h left the DUT at %0t ns",
                     data_o.data, $time));
        end
        else
        begin
            check_port("out_port_o", noc_params::port_t'(port), out_port_o);
            check_flit("data_o", exp_q[port][0], data_o);
            exp_q[port].delete(0);
            held_q[src].delete(0);
        end
    endtask

    task automatic send_flit(input int vc, input int label,
                             input logic [noc_params::FLIT_DATA_SIZE-1:0] payload);
        noc_params::flit_t f;
        logic              is_head;
        logic              accepted;
        int                waited;
        f.flit_label = noc_params::flit_label_t'(label);
        f.vc_id      = vc[noc_params::VC_SIZE-1:0];
        f.data       = payload;
        is_head  = (f.flit_label == noc_params::HEAD) || (f.flit_label == noc_params::HEADTAIL);
        accepted = is_head ? !pkt_open[vc] : pkt_open[vc];
        waited   = 0;
        // A new head needs its VC drained, and upstream obeys on/off
        while ((is_head && accepted && held_q[vc].size() != 0) || !on_off_o[vc])
        begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > TIMEOUT_CYCLES)
                stop_run($sformatf("Timeout waiting for VC %0d to take a new flit", vc));
        end
        data_i  = f;
        valid_i = 1'b1;
        @(posedge clk);
        if (accepted)
        begin
            held_q[vc].push_back(payload);
            pkt_open[vc] = (f.flit_label == noc_params::HEAD) || (f.flit_label == noc_params::BODY);
        end
        #2;
        valid_i = 1'b0;
    endtask

    task automatic run_trace();
        int                                    fd;
        int                                    n;
        int                                    vc;
        int                                    label;
        int                                    port;
        logic [noc_params::FLIT_DATA_SIZE-1:0] payload;
        string                                 line;
        byte                                   kind;
        noc_params::flit_t                     f;
        fd = $fopen("dv/input_unit_trace.txt", "r");
        if (fd == 0)
            stop_run("Cannot open the trace file dv/input_unit_trace.txt");
        while (!$feof(fd))
        begin
            line = "";
            n    = $fgets(line, fd);
            kind = (line.len() > 0) ? line.getc(0) : "#";
            if (kind == "S")
            begin
                n = $sscanf(line.substr(1, line.len() - 1), "%d %d %h", vc, label, payload);
                if (n != 3 || vc >= noc_params::VC_NUM)
                    stop_run($sformatf("Bad send line in trace: %s", line));
                send_flit(vc, label, payload);
            end
            else if (kind == "E")
            begin
                n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d %h", port, vc, label,
                            payload);
                if (n != 4 || port >= noc_params::PORT_NUM)
                    stop_run($sformatf("Bad expect line in trace: %s", line));
                f.flit_label = noc_params::flit_label_t'(label);
                f.vc_id      = vc[noc_params::VC_SIZE-1:0];
                f.data       = payload;
                exp_q[port].push_back(f);
            end
            else if (kind == "X")
            begin
                err_pending++;
            end
            else if (kind != "#" && kind != "\n" && kind != " ")
            begin
                stop_run($sformatf("Unknown line in trace: %s", line));
            end
        end
        $fclose(fd);
    endtask

    function automatic logic all_done();
        logic done;
        done = (err_pending == 0);
        for (int p = 0; p < noc_params::PORT_NUM; p++)
        begin
            if (exp_q[p].size() != 0)
                done = 1'b0;
        end
        for (int v = 0; v < noc_params::VC_NUM; v++)
        begin
            if (held_q[v].size() != 0)
                done = 1'b0;
        end
        return done;
    endfunction

    // Outputs, error strobes and on/off are all sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (valid_o)
                match_output();
            if (error_o)
            begin
                if (err_pending == 0)
                    stop_run($sformatf("Unexpected error strobe at %0t ns", $time));
                else
                    err_pending--;
            end
            for (int v = 0; v < noc_params::VC_NUM; v++)
            begin
                check_on_off(v, (noc_params::BUFFER_SIZE - held_q[v].size())
                                >= noc_params::PIPELINE_DEPTH, on_off_o[v]);
            end
        end
    end

    initial
    begin
        int waited;
        rst         = 1'b1;
        valid_i     = 1'b0;
        data_i      = '0;
        pkt_open    = '0;
        err_pending = 0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        run_trace();
        waited = 0;
        while (!all_done())
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES)
                stop_run("Timeout waiting for the expected outputs and error strobes");
        end
        repeat (4) @(posedge clk);   // Room for a stray flit to show up
        $display("sim passed");
        $finish;
    end

endmodule

// File: input_unit.f
design/noc_params.sv
design/circular_buffer.sv
design/route_compute.sv
design/input_buffer.sv
design/vc_allocator.sv
design/switch_allocator.sv
design/input_unit.sv
dv/tb_input_unit.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    -f input_unit.f --top-module tb_input_unit -o tb_input_unit
./obj_dir/tb_input_unit
